//--- source/ciPkg.sv
package ciPkg;

  // Custom-instruction bus words
  typedef logic [31:0] ciWord_t;
  typedef logic [7:0]  ciId_t;

  // Identifiers answered on the bus
  localparam ciId_t swapByteId  = 8'd1;
  localparam ciId_t profileId   = 8'd8;
  localparam ciId_t grayscaleId = 8'd12;

  // Unit owning the current start strobe
  typedef enum logic [1:0] {
    unitNone,
    unitSwap,
    unitGray,
    unitProfile
  } unitSelect_t;

  // Top bit set after 16 cycles ends the processor reset
  localparam int resetCountWidth = 5;

endpackage

//--- source/profilePkg.sv
package profilePkg;

  localparam int counterCount = 4;

  typedef logic [31:0]             count_t;
  typedef logic [1:0]              counterIndex_t;
  typedef logic [counterCount-1:0] counterMask_t;

  // Control word layout in ciDataB
  localparam int enableLsb  = 0; // Bits 3..0
  localparam int disableLsb = 4; // Bits 7..4
  localparam int clearLsb   = 8; // Bits 11..8

  /*
   * Events per counter:
   * 0 all cycles, 1 stall cycles, 2 bus-idle cycles,
   * 3 stall cycles with the bus busy
   */

endpackage

//--- source/resetSequencer.sv
`timescale 1ns/1ps

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);
  import ciPkg::*;

  logic [resetCountWidth-1:0] resetCount;

  // Restart the sequence whenever lock drops
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[resetCountWidth-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign cpuReset = ~resetCount[resetCountWidth-1]; // Held until top bit sets

endmodule

//--- source/ciDispatcher.sv
`timescale 1ns/1ps

module ciDispatcher (
  input  logic                ciStart,
  input  ciPkg::ciId_t        ciN,
  output ciPkg::unitSelect_t  unitSelect,
  output logic                profileStart
);
  import ciPkg::*;

  // Only the unit with the matching id takes the strobe
  always_comb begin
    unitSelect = unitNone;
    if (ciStart) begin
      case (ciN)
        swapByteId:  unitSelect = unitSwap;
        grayscaleId: unitSelect = unitGray;
        profileId:   unitSelect = unitProfile;
        default:     unitSelect = unitNone; // Unknown id, no done
      endcase
    end
  end

  assign profileStart = (unitSelect == unitProfile);

endmodule

//--- source/ciDataOps.sv
`timescale 1ns/1ps

module ciDataOps (
  input  ciPkg::ciWord_t ciDataA,
  input  ciPkg::ciWord_t ciDataB,
  output ciPkg::ciWord_t swapResult,
  output ciPkg::ciWord_t grayResult
);
  import ciPkg::*;

  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] graySum;

  // Full reversal or swap inside each half word
  always_comb begin
    if (ciDataB[0]) begin
      swapResult = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
    end else begin
      swapResult = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  // RGB565 fields scaled up to 8 bits
  assign red   = {ciDataA[15:11], 3'b000};
  assign green = {ciDataA[10:5], 2'b00};
  assign blue  = {ciDataA[4:0], 3'b000};

  // Weights sum to 256, so 16 bits never overflow
  assign graySum = (16'(red) * 16'd54)
                 + (16'(green) * 16'd183)
                 + (16'(blue) * 16'd19);

  assign grayResult = ciWord_t'(graySum[15:8]);

endmodule

//--- source/profileControl.sv
`timescale 1ns/1ps

module profileControl (
  input  logic                     s_systemClock,
  input  logic                     cpuReset,
  input  logic                     profileStart,
  input  ciPkg::ciWord_t           ciDataB,
  input  logic                     cpuIsStalled,
  input  logic                     busIdle,
  output profilePkg::counterMask_t counterEnable,
  output profilePkg::counterMask_t counterClear,
  output profilePkg::counterMask_t counterEvent
);
  import profilePkg::*;

  counterMask_t enableReg;
  counterMask_t enableBits;
  counterMask_t disableBits;
  counterMask_t clearBits;

  assign enableBits  = ciDataB[enableLsb +: counterCount];
  assign disableBits = ciDataB[disableLsb +: counterCount];
  assign clearBits   = ciDataB[clearLsb +: counterCount];

  // Disable applied after enable so it wins
  always_ff @(posedge s_systemClock) begin
    if (cpuReset) begin
      enableReg <= '0;
    end else if (profileStart) begin
      enableReg <= (enableReg | enableBits) & ~disableBits;
    end
  end

  assign counterEnable = enableReg;
  assign counterClear  = profileStart ? clearBits : '0; // Only with a sampled instruction

  // Event levels, counter 0 in bit 0
  assign counterEvent = {
    cpuIsStalled & ~busIdle,
    busIdle,
    cpuIsStalled,
    1'b1
  };

endmodule

//--- source/profileCounter.sv
`timescale 1ns/1ps

module profileCounter (
  input  logic               s_systemClock,
  input  logic               cpuReset,
  input  logic               enable,
  input  logic               clear,
  input  logic               countEvent,
  output profilePkg::count_t count
);
  import profilePkg::*;

  count_t countReg;

  // Clear beats counting at the same edge
  always_ff @(posedge s_systemClock) begin
    if (cpuReset || clear) begin
      countReg <= '0;
    end else if (enable && countEvent) begin
      countReg <= countReg + 1'b1; // Wraps at 32 bits
    end
  end

  assign count = countReg;

endmodule

//--- source/ciResultCollector.sv
`timescale 1ns/1ps

module ciResultCollector (
  input  logic               s_systemClock,
  input  logic               cpuReset,
  input  ciPkg::unitSelect_t unitSelect,
  input  ciPkg::ciWord_t     ciDataA,
  input  ciPkg::ciWord_t     swapResult,
  input  ciPkg::ciWord_t     grayResult,
  input  profilePkg::count_t counterValues [profilePkg::counterCount],
  output logic               ciDone,
  output ciPkg::ciWord_t     ciResult
);
  import ciPkg::*;
  import profilePkg::*;

  counterIndex_t counterIndex;
  ciWord_t       resultNext;

  assign counterIndex = ciDataA[1:0];

  // Result is zero unless some unit owns the strobe
  always_comb begin
    case (unitSelect)
      unitSwap: begin
        resultNext = swapResult;
      end
      unitGray: begin
        resultNext = grayResult;
      end
      unitProfile: begin
        resultNext = counterValues[counterIndex]; // Value before this edge
      end
      default: begin
        resultNext = '0;
      end
    endcase
  end

  // One-cycle reply, done and result together
  always_ff @(posedge s_systemClock) begin
    if (cpuReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= (unitSelect != unitNone);
      ciResult <= resultNext;
    end
  end

endmodule

//--- source/or1420CiTop.sv
`timescale 1ns/1ps

module or1420CiTop (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           ciStart,
  input  ciPkg::ciId_t   ciN,
  input  ciPkg::ciWord_t ciDataA,
  input  ciPkg::ciWord_t ciDataB,
  input  logic           cpuIsStalled,
  input  logic           busIdle,
  output logic           ciDone,
  output ciPkg::ciWord_t ciResult,
  output logic           cpuReset
);

  ciPkg::unitSelect_t       unitSelect;
  logic                     profileStart;
  ciPkg::ciWord_t           swapResult;
  ciPkg::ciWord_t           grayResult;
  profilePkg::counterMask_t counterEnable;
  profilePkg::counterMask_t counterClear;
  profilePkg::counterMask_t counterEvent;
  profilePkg::count_t       counterValues [profilePkg::counterCount];

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset)
  );

  ciDispatcher dispatch (
    .ciStart(ciStart),
    .ciN(ciN),
    .unitSelect(unitSelect),
    .profileStart(profileStart)
  );

  ciDataOps dataOps (
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .swapResult(swapResult),
    .grayResult(grayResult)
  );

  profileControl profCtrl (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .profileStart(profileStart),
    .ciDataB(ciDataB),
    .cpuIsStalled(cpuIsStalled),
    .busIdle(busIdle),
    .counterEnable(counterEnable),
    .counterClear(counterClear),
    .counterEvent(counterEvent)
  );

  // One counter per event
  for (genvar i = 0; i < profilePkg::counterCount; i++) begin : gCounter
    profileCounter counter (
      .s_systemClock(s_systemClock),
      .cpuReset(cpuReset),
      .enable(counterEnable[i]),
      .clear(counterClear[i]),
      .countEvent(counterEvent[i]),
      .count(counterValues[i])
    );
  end

  ciResultCollector collector (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .unitSelect(unitSelect),
    .ciDataA(ciDataA),
    .swapResult(swapResult),
    .grayResult(grayResult),
    .counterValues(counterValues),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

//--- bench/ciModel.svh
`ifndef CIMODEL_SVH
`define CIMODEL_SVH

// Expected top-level outputs after one rising edge
typedef struct packed {
  logic    reset;
  logic    done;
  ciWord_t result;
} reply_t;

int unsigned  modelResetCount;
counterMask_t modelEnable;
count_t       modelCount [counterCount];
reply_t       replyQueue [$];

// Byte i comes from byte 3-i, or from its neighbour in the same half word
function automatic ciWord_t swapModel(input ciWord_t a, input logic halfMode);
  ciWord_t result;
  int      source;
  for (int i = 0; i < 4; i++) begin
    source = halfMode ? (i ^ 1) : (3 - i);
    result[8*i +: 8] = a[8*source +: 8];
  end
  return result;
endfunction

function automatic ciWord_t grayModel(input ciWord_t pixel);
  int red;
  int green;
  int blue;
  red   = int'(pixel[15:11]) * 8;
  green = int'(pixel[10:5]) * 4;
  blue  = int'(pixel[4:0]) * 8;
  return ciWord_t'((red * 54 + green * 183 + blue * 19) / 256);
endfunction

task automatic stepModel(input logic locked, input logic start, input ciId_t id,
                         input ciWord_t a, input ciWord_t b,
                         input logic stalled, input logic idle);
  reply_t       reply;
  logic         inReset;
  logic         profileHit;
  counterMask_t events;
  inReset    = (modelResetCount < 16); // Reset state before this edge
  profileHit = !inReset && start && (id == profileId);
  reply      = '0;
  events     = {stalled & ~idle, idle, stalled, 1'b1};
  if (!inReset && start && id == swapByteId) begin
    reply.done   = 1'b1;
    reply.result = swapModel(a, b[0]);
  end else if (!inReset && start && id == grayscaleId) begin
    reply.done   = 1'b1;
    reply.result = grayModel(a);
  end else if (profileHit) begin
    reply.done   = 1'b1;
    reply.result = modelCount[a[1:0]]; // Count before the edge
  end
  for (int i = 0; i < counterCount; i++) begin
    if (inReset || (profileHit && b[clearLsb + i])) begin
      modelCount[i] = '0;
    end else if (modelEnable[i] && events[i]) begin
      modelCount[i] = modelCount[i] + 1;
    end
  end
  if (inReset) begin
    modelEnable = '0;
  end else if (profileHit) begin
    modelEnable = (modelEnable | b[enableLsb +: counterCount]) & ~b[disableLsb +: counterCount];
  end
  if (!locked) begin
    modelResetCount = 0;
  end else if (modelResetCount < 16) begin
    modelResetCount++;
  end
  reply.reset = (modelResetCount < 16);
  replyQueue.push_back(reply);
endtask

`endif

//--- bench/ciTopBench.sv
`timescale 1ns/1ps

module ciTopBench;
  import ciPkg::*;
  import profilePkg::*;

  `include "ciModel.svh"

  localparam int clockPeriod = 100;
  localparam int swapTests   = 200;
  localparam int grayTests   = 200;
  localparam int profileOps  = 300;
  localparam int mixOps      = 300;
  localparam int totalInstructions = swapTests + grayTests + profileOps + mixOps;

  logic    s_systemClock;
  logic    s_pllLocked;
  logic    ciStart;
  ciId_t   ciN;
  ciWord_t ciDataA;
  ciWord_t ciDataB;
  logic    cpuIsStalled;
  logic    busIdle;
  logic    ciDone;
  ciWord_t ciResult;
  logic    cpuReset;

  string testName;
  int    testChecks;
  int    testErrors;
  int    totalChecks;
  int    totalErrors;
  int    testCount;

  or1420CiTop dut (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .cpuIsStalled(cpuIsStalled),
    .busIdle(busIdle),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .cpuReset(cpuReset)
  );

  initial s_systemClock = 1'b0;
  always #(clockPeriod / 2) s_systemClock = ~s_systemClock;

  // Model sees the same inputs as the DUT
  always @(posedge s_systemClock) begin
    stepModel(s_pllLocked, ciStart, ciN, ciDataA, ciDataB, cpuIsStalled, busIdle);
  end

  task automatic checkWord(input string what, input ciWord_t expected, input ciWord_t actual);
    testChecks++;
    if (actual !== expected) begin
      testErrors++;
      $display("Fail %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    testChecks++;
    if (actual !== expected) begin
      testErrors++;
      $display("Fail %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
  endtask

  task automatic checkReply();
    reply_t expected;
    if (replyQueue.size() == 0) begin
      testErrors++;
      $display("Error in %s: the model has no reply for the cycle at %0t", testName, $time);
      return;
    end
    expected = replyQueue.pop_front();
    checkFlag("cpuReset", expected.reset, cpuReset);
    checkFlag("ciDone", expected.done, ciDone);
    checkWord("ciResult", expected.result, ciResult); // Zero whenever no done
  endtask

  // Drive on the falling edge, check the reply one edge later
  task automatic driveCycle(input logic start, input ciId_t id, input ciWord_t a,
                            input ciWord_t b);
    ciStart      = start;
    ciN          = id;
    ciDataA      = a;
    ciDataB      = b;
    cpuIsStalled = 1'($urandom_range(0, 1));
    busIdle      = 1'($urandom_range(0, 1));
    @(negedge s_systemClock);
    checkReply();
  endtask

  task automatic finishTest();
    driveCycle(1'b0, '0, '0, '0); // Drains the last reply
    $display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
    totalChecks += testChecks;
    totalErrors += testErrors;
    testCount++;
    testChecks = 0;
    testErrors = 0;
  endtask

  function automatic ciId_t randomId();
    case ($urandom_range(0, 3))
      0: return swapByteId;
      1: return grayscaleId;
      2: return profileId;
      default: return ciId_t'($urandom_range(0, 255)); // Mostly unknown ids
    endcase
  endfunction

  function automatic ciWord_t randomControl();
    ciWord_t word;
    word = $urandom;
    if ($urandom_range(0, 3) != 0) begin
      word[disableLsb +: counterCount] = '0;
    end
    if ($urandom_range(0, 7) != 0) begin
      word[clearLsb +: counterCount] = '0; // Clears kept rare
    end
    return word;
  endfunction

  initial begin
    int      edges;
    ciWord_t b;
    void'($urandom(24093));
    s_pllLocked  = 1'b0;
    ciStart      = 1'b0;
    ciN          = '0;
    ciDataA      = '0;
    ciDataB      = '0;
    cpuIsStalled = 1'b0;
    busIdle      = 1'b0;
    testName     = "reset";
    testChecks   = 0;
    testErrors   = 0;
    totalChecks  = 0;
    totalErrors  = 0;
    testCount    = 0;

    driveCycle(1'b0, '0, '0, '0);
    repeat (2) driveCycle(1'b1, randomId(), $urandom, $urandom);
    s_pllLocked = 1'b1;
    edges = 0;
    while (cpuReset === 1'b1 && edges < 40) begin
      driveCycle(1'b1, randomId(), $urandom, $urandom);
      edges++;
    end
    checkWord("edges in reset", ciWord_t'(16), ciWord_t'(edges));
    finishTest();

    testName = "swap";
    for (int n = 0; n < swapTests; n++) begin
      b    = $urandom;
      b[0] = n[0]; // Both modes
      driveCycle(1'b1, swapByteId, $urandom, b);
    end
    finishTest();

    testName = "grayscale";
    for (int n = 0; n < grayTests; n++) begin
      driveCycle(1'b1, grayscaleId, $urandom, $urandom);
    end
    finishTest();

    testName = "profile";
    driveCycle(1'b1, profileId, '0, 32'h0000_000F);
    repeat (10) driveCycle(1'b0, '0, '0, '0);
    driveCycle(1'b1, profileId, '0, 32'h0000_00FF); // Disable wins
    for (int i = 0; i < counterCount; i++) begin
      driveCycle(1'b1, profileId, ciWord_t'(counterCount - 1 - i), '0); // Counter 0 read last
    end
    driveCycle(1'b1, profileId, '0, 32'h0000_0F0F); // Clear all, enable again
    for (int i = 0; i < counterCount; i++) begin
      driveCycle(1'b1, profileId, ciWord_t'(i), '0);
    end
    for (int n = 0; n < profileOps; n++) begin
      driveCycle($urandom_range(0, 3) != 0, profileId, $urandom, randomControl());
    end
    finishTest();

    testName = "mix";
    for (int n = 0; n < mixOps; n++) begin
      driveCycle(1'b1, randomId(), $urandom, randomControl());
    end
    finishTest();

    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((totalInstructions + 200) * clockPeriod * 2);
    $display("Timeout: the tests did not finish within %0t", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+bench
source/ciPkg.sv
source/profilePkg.sv
source/resetSequencer.sv
source/ciDispatcher.sv
source/ciDataOps.sv
source/profileControl.sv
source/profileCounter.sv
source/ciResultCollector.sv
source/or1420CiTop.sv
bench/ciTopBench.sv

//--- run.sh
#!/bin/sh
# Build and run the custom-instruction testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module ciTopBench \
  -f sources.f -o ciTopBench > build.log 2>&1

./obj_dir/ciTopBench > sim.log 2>&1
cat sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
else
  exit 1
fi
